// ==== design/cp0_pkg.sv ====
`default_nettype none

package cp0_pkg;

    // a cp0 address is {register number, select}, the same as the mfc0/mtc0 fields
    typedef struct packed {
        logic [4:0] num;
        logic [2:0] sel;
    } cp0_addr_t;

    localparam cp0_addr_t INDEX    = '{num: 5'd0,  sel: 3'd0};
    localparam cp0_addr_t ENTRYLO0 = '{num: 5'd2,  sel: 3'd0};
    localparam cp0_addr_t ENTRYLO1 = '{num: 5'd3,  sel: 3'd0};
    localparam cp0_addr_t BADVADDR = '{num: 5'd8,  sel: 3'd0};
    localparam cp0_addr_t COUNT    = '{num: 5'd9,  sel: 3'd0};
    localparam cp0_addr_t ENTRYHI  = '{num: 5'd10, sel: 3'd0};
    localparam cp0_addr_t COMPARE  = '{num: 5'd11, sel: 3'd0};
    localparam cp0_addr_t STATUS   = '{num: 5'd12, sel: 3'd0};
    localparam cp0_addr_t CAUSE    = '{num: 5'd13, sel: 3'd0};
    localparam cp0_addr_t EPC      = '{num: 5'd14, sel: 3'd0};
    localparam cp0_addr_t CONFIG   = '{num: 5'd16, sel: 3'd0};
    localparam cp0_addr_t CONFIG1  = '{num: 5'd16, sel: 3'd1};

    typedef enum logic [4:0] {
        INT  = 5'd0,
        ADEL = 5'd4,
        ADES = 5'd5,
        SYS  = 5'd8,
        BP   = 5'd9,
        RI   = 5'd10,
        OV   = 5'd12
    } exc_code_t;

    localparam logic [31:0] STATUS_RESET = 32'h0040_0000; // only BEV set
    // kseg0 cached (K0 = 3), one level of TLB entries in Config.MT
    localparam logic [31:0] CONFIG_RESET =
        {1'b1, 15'd0, 1'b0, 2'd0, 3'd0, 3'd1, 4'd0, 3'd3};
    localparam logic [31:0] CONFIG1_RESET =
        {1'b0, 6'd16, 3'd2, 3'd3, 3'd1, 3'd2, 3'd3, 3'd1, 7'd0}; // 17 entry tlb, 2-way caches

    localparam logic [1:0] AXI_OKAY = 2'b00;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        in_delay_slot;
        logic        fetch_adel;
        logic        ri;
        logic        ov;
        logic        syscall;
        logic        brk;
        logic        data_adel;
        logic        data_ades;
        logic [31:0] bad_addr;
    } exc_req_t;

    typedef struct packed {
        logic        valid;
        exc_code_t   exccode;
        logic        bd;
        logic        epc_valid;     // low when the exception is taken under exl
        logic [31:0] epc;
        logic        badvaddr_valid;
        logic [31:0] badvaddr;
    } cp0_update_t;

    typedef struct packed {
        logic        probe_valid;   // tlbp
        logic        read_valid;    // tlbr
        logic [31:0] index;
        logic [31:0] entryhi;
        logic [31:0] entrylo0;
        logic [31:0] entrylo1;
    } tlb_result_t;

    typedef struct packed {
        logic        wr_en;
        logic        rd_en;
        cp0_addr_t   waddr;
        cp0_addr_t   raddr;
        logic [31:0] wdata;
    } cp0_access_t;

    typedef struct packed {
        logic [31:0] epc;
        logic [31:0] index;
        logic [31:0] entryhi;
        logic [31:0] entrylo0;
        logic [31:0] entrylo1;
        logic [2:0]  config_k0;
    } cp0_view_t;

endpackage

`default_nettype wire

// ==== design/cp0_axil_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_axil_port #(
    parameter int ADDR_W = 10
) (
    input  wire                  clk,
    input  wire                  rst,

    input  wire [ADDR_W-1:0]     awaddr,
    input  wire                  awvalid,
    output logic                 awready,
    input  wire [31:0]           wdata,
    input  wire [3:0]            wstrb,
    input  wire                  wvalid,
    output logic                 wready,
    output logic [1:0]           bresp,
    output logic                 bvalid,
    input  wire                  bready,

    input  wire [ADDR_W-1:0]     araddr,
    input  wire                  arvalid,
    output logic                 arready,
    output logic [31:0]          rdata,
    output logic [1:0]           rresp,
    output logic                 rvalid,
    input  wire                  rready,

    output cp0_pkg::cp0_access_t access,
    input  wire [31:0]           rdata_in
);

    logic wr_ready_q;
    logic rd_ready_q;
    logic wr_go;
    logic rd_go;

    // aw and w are always taken on the same edge
    assign awready = wr_ready_q;
    assign wready  = wr_ready_q;
    assign arready = rd_ready_q;

    assign wr_go = wr_ready_q & awvalid & wvalid;
    assign rd_go = rd_ready_q & arvalid;

    assign bresp = cp0_pkg::AXI_OKAY;
    assign rresp = cp0_pkg::AXI_OKAY;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ready_q <= 1'b0;
            rd_ready_q <= 1'b0;
            bvalid     <= 1'b0;
            rvalid     <= 1'b0;
        end else begin
            // ready is a single-cycle pulse, held off while a response is outstanding
            wr_ready_q <= awvalid & wvalid & ~bvalid & ~wr_ready_q;
            rd_ready_q <= arvalid & ~rvalid & ~rd_ready_q;

            if (wr_go) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end

            if (rd_go) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // no new read is accepted until rvalid drops, so rdata holds under back-pressure
    always_ff @(posedge clk) begin
        if (rd_go) begin
            rdata <= rdata_in;
        end
    end

    always_comb begin
        access.wr_en = wr_go & (wstrb == 4'hf); // partial writes are acked but dropped
        access.rd_en = rd_go;
        access.waddr = awaddr[9:2];             // byte address is num*32 + sel*4
        access.raddr = araddr[9:2];
        access.wdata = wdata;
    end

endmodule

`default_nettype wire

// ==== design/exc_encoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module exc_encoder (
    input  wire                   clk,
    input  wire                   rst,
    input  wire cp0_pkg::exc_req_t req,
    input  wire                   status_exl,
    output cp0_pkg::cp0_update_t  update
);

    cp0_pkg::exc_req_t  req_q;
    cp0_pkg::exc_code_t code;
    logic               any_exc;
    logic               addr_err;

    always_ff @(posedge clk) begin
        req_q <= req;
        if (rst) begin
            req_q.valid <= 1'b0;
        end
    end

    // fetch errors come first since nothing else of the instruction is known
    always_comb begin
        any_exc = 1'b1;
        code    = cp0_pkg::INT;
        if (req_q.fetch_adel) begin
            code = cp0_pkg::ADEL;
        end else if (req_q.ri) begin
            code = cp0_pkg::RI;
        end else if (req_q.ov) begin
            code = cp0_pkg::OV;
        end else if (req_q.syscall) begin
            code = cp0_pkg::SYS;
        end else if (req_q.brk) begin
            code = cp0_pkg::BP;
        end else if (req_q.data_adel) begin
            code = cp0_pkg::ADEL;
        end else if (req_q.data_ades) begin
            code = cp0_pkg::ADES;
        end else begin
            any_exc = 1'b0;
        end
    end

    assign addr_err = (code == cp0_pkg::ADEL) || (code == cp0_pkg::ADES);

    always_comb begin
        update                = '0;
        update.valid          = req_q.valid & any_exc;
        update.exccode        = code;
        update.epc_valid      = ~status_exl; // nested exceptions keep the first epc
        update.bd             = req_q.in_delay_slot;
        // a delay slot restarts at the branch in front of it
        update.epc            = req_q.in_delay_slot ? req_q.pc - 32'd4 : req_q.pc;
        update.badvaddr_valid = any_exc & addr_err;
        update.badvaddr       = req_q.fetch_adel ? req_q.pc : req_q.bad_addr;
    end

endmodule

`default_nettype wire

// ==== design/cp0_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_regs #(
    parameter int          INDEX_W      = 4,
    parameter logic [31:0] STATUS_INIT  = 32'h0,
    parameter logic [31:0] CONFIG_INIT  = 32'h0,
    parameter logic [31:0] CONFIG1_INIT = 32'h0
) (
    input  wire                       clk,
    input  wire                       rst,
    input  wire [5:0]                 irq,
    input  wire cp0_pkg::cp0_access_t access,
    output logic [31:0]               rdata,
    input  wire cp0_pkg::cp0_update_t update,
    input  wire                       eret,
    input  wire cp0_pkg::tlb_result_t tlb,
    output logic                      status_exl,
    output logic                      int_pending,
    output cp0_pkg::cp0_view_t        view
);

    logic [32:0] count_q;   // lsb is the half-rate prescaler
    logic [31:0] compare_q;
    logic [31:0] status_q;
    logic [31:0] cause_q;
    logic [31:0] index_q;
    logic [31:0] entryhi_q;
    logic [31:0] config_q;
    logic [31:0] epc_q;
    logic [31:0] badvaddr_q;
    logic [31:0] entrylo0_q;
    logic [31:0] entrylo1_q;
    logic        timer_hit;
    logic        sw_wr_epc;

    assign timer_hit = (compare_q != 32'd0) && (count_q[32:1] == compare_q);
    assign sw_wr_epc = access.wr_en && (access.waddr == cp0_pkg::EPC);

    always_ff @(posedge clk) begin
        if (rst) begin
            count_q   <= '0;
            compare_q <= '0;
            status_q  <= STATUS_INIT;
            cause_q   <= '0;
            index_q   <= '0;
            entryhi_q <= '0;
            config_q  <= CONFIG_INIT;
        end else begin
            count_q        <= count_q + 33'd1;
            cause_q[15:10] <= {cause_q[30] | irq[5], irq[4:0]}; // timer shares hw int 5

            if (timer_hit) begin
                cause_q[30] <= 1'b1;
            end

            if (eret) begin
                status_q[1] <= 1'b0;
            end

            if (update.valid) begin
                cause_q[6:2] <= update.exccode;
                status_q[1]  <= 1'b1;
                if (update.epc_valid) begin
                    cause_q[31] <= update.bd;
                end
            end

            if (tlb.probe_valid) begin
                index_q <= tlb.index;
            end
            if (tlb.read_valid) begin
                entryhi_q <= tlb.entryhi;
            end

            // software writes land last and so win over the hardware sources above
            if (access.wr_en) begin
                case (access.waddr)
                    cp0_pkg::INDEX: begin
                        index_q <= {{(32 - INDEX_W){1'b0}}, access.wdata[INDEX_W-1:0]};
                    end
                    cp0_pkg::ENTRYHI: begin
                        entryhi_q <= {access.wdata[31:13], 5'h0, access.wdata[7:0]};
                    end
                    cp0_pkg::COUNT: begin
                        count_q <= {access.wdata, 1'b0};
                    end
                    cp0_pkg::COMPARE: begin
                        compare_q   <= access.wdata;
                        cause_q[30] <= 1'b0; // acknowledges the timer interrupt
                    end
                    cp0_pkg::STATUS: begin
                        status_q[15:8] <= access.wdata[15:8];
                        status_q[1]    <= access.wdata[1];
                        status_q[0]    <= access.wdata[0];
                    end
                    cp0_pkg::CAUSE: begin
                        cause_q[9:8] <= access.wdata[9:8]; // software interrupts only
                    end
                    cp0_pkg::CONFIG: begin
                        config_q[2:0] <= access.wdata[2:0];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (update.valid && update.badvaddr_valid) begin
            badvaddr_q <= update.badvaddr;
        end

        if (update.valid) begin
            if (update.epc_valid) begin
                epc_q <= update.epc;
            end
        end else if (sw_wr_epc) begin
            epc_q <= access.wdata;
        end

        if (tlb.read_valid) begin
            entrylo0_q <= tlb.entrylo0;
            entrylo1_q <= tlb.entrylo1;
        end
        if (access.wr_en && access.waddr == cp0_pkg::ENTRYLO0) begin
            entrylo0_q <= {6'h0, access.wdata[25:0]};
        end
        if (access.wr_en && access.waddr == cp0_pkg::ENTRYLO1) begin
            entrylo1_q <= {6'h0, access.wdata[25:0]};
        end
    end

    always_comb begin
        rdata = '0;
        if (access.rd_en) begin
            if (access.wr_en && access.waddr == access.raddr) begin
                rdata = access.wdata;
            end else begin
                case (access.raddr)
                    cp0_pkg::INDEX:    rdata = index_q;
                    cp0_pkg::ENTRYLO0: rdata = entrylo0_q;
                    cp0_pkg::ENTRYLO1: rdata = entrylo1_q;
                    cp0_pkg::BADVADDR: rdata = badvaddr_q;
                    cp0_pkg::COUNT:    rdata = count_q[32:1];
                    cp0_pkg::ENTRYHI:  rdata = entryhi_q;
                    cp0_pkg::COMPARE:  rdata = compare_q;
                    cp0_pkg::STATUS:   rdata = status_q;
                    cp0_pkg::CAUSE:    rdata = cause_q;
                    cp0_pkg::EPC:      rdata = epc_q;
                    cp0_pkg::CONFIG:   rdata = config_q;
                    cp0_pkg::CONFIG1:  rdata = CONFIG1_INIT;
                    default:           rdata = '0;
                endcase
            end
        end
    end

    assign status_exl = status_q[1];

    // IP masked by IM, enabled by IE, never while at exception level
    assign int_pending = (|(cause_q[15:8] & status_q[15:8])) & status_q[0] & ~status_q[1];

    always_comb begin
        view.epc       = epc_q;
        view.index     = index_q;
        view.entryhi   = entryhi_q;
        view.entrylo0  = entrylo0_q;
        view.entrylo1  = entrylo1_q;
        view.config_k0 = config_q[2:0];
    end

endmodule

`default_nettype wire

// ==== design/cp0_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_top #(
    parameter int ADDR_W  = 10,
    parameter int INDEX_W = 4
) (
    input  wire                       clk,
    input  wire                       rst,

    input  wire [ADDR_W-1:0]          awaddr,
    input  wire                       awvalid,
    output logic                      awready,
    input  wire [31:0]                wdata,
    input  wire [3:0]                 wstrb,
    input  wire                       wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  wire                       bready,
    input  wire [ADDR_W-1:0]          araddr,
    input  wire                       arvalid,
    output logic                      arready,
    output logic [31:0]               rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  wire                       rready,

    input  wire [5:0]                 irq,
    input  wire cp0_pkg::exc_req_t    exc_req,
    input  wire                       eret,
    input  wire cp0_pkg::tlb_result_t tlb,
    output logic                      int_pending,
    output cp0_pkg::cp0_view_t        view
);

    cp0_pkg::cp0_access_t access;
    cp0_pkg::cp0_update_t update;
    logic [31:0]          reg_rdata;
    logic                 status_exl;

    cp0_axil_port #(
        .ADDR_W(ADDR_W)
    ) u_port (
        .clk      (clk),
        .rst      (rst),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wvalid   (wvalid),
        .wready   (wready),
        .bresp    (bresp),
        .bvalid   (bvalid),
        .bready   (bready),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rresp    (rresp),
        .rvalid   (rvalid),
        .rready   (rready),
        .access   (access),
        .rdata_in (reg_rdata)
    );

    exc_encoder u_encoder (
        .clk        (clk),
        .rst        (rst),
        .req        (exc_req),
        .status_exl (status_exl),
        .update     (update)
    );

    cp0_regs #(
        .INDEX_W      (INDEX_W),
        .STATUS_INIT  (cp0_pkg::STATUS_RESET),
        .CONFIG_INIT  (cp0_pkg::CONFIG_RESET),
        .CONFIG1_INIT (cp0_pkg::CONFIG1_RESET)
    ) u_regs (
        .clk         (clk),
        .rst         (rst),
        .irq         (irq),
        .access      (access),
        .rdata       (reg_rdata),
        .update      (update),
        .eret        (eret),
        .tlb         (tlb),
        .status_exl  (status_exl),
        .int_pending (int_pending),
        .view        (view)
    );

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset drops on a falling edge like every other testbench input
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== test/cp0_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cp0_tb;

    localparam int CLK_PERIOD      = 40;
    localparam int HS_LIMIT        = 16;    // cycles a bus handshake may take
    localparam int TIMER_COMPARE   = 10;
    // the tests take roughly 600 cycles, the rest is margin
    localparam int WATCHDOG_CYCLES = 2000;

    logic                 clk;
    logic                 rst;
    logic [9:0]           awaddr;
    logic                 awvalid;
    logic                 awready;
    logic [31:0]          wdata;
    logic [3:0]           wstrb;
    logic                 wvalid;
    logic                 wready;
    logic [1:0]           bresp;
    logic                 bvalid;
    logic                 bready;
    logic [9:0]           araddr;
    logic                 arvalid;
    logic                 arready;
    logic [31:0]          rdata;
    logic [1:0]           rresp;
    logic                 rvalid;
    logic                 rready;
    logic [5:0]           irq;
    cp0_pkg::exc_req_t    exc_req;
    logic                 eret;
    cp0_pkg::tlb_result_t tlb;
    logic                 int_pending;
    cp0_pkg::cp0_view_t   view;

    integer seed;
    int     checks;
    int     mismatches;
    int     failures;

    tb_clock #(
        .PERIOD_NS    (CLK_PERIOD),
        .RESET_CYCLES (16)
    ) u_clock (
        .clk (clk),
        .rst (rst)
    );

    cp0_top #(
        .ADDR_W  (10),
        .INDEX_W (4)
    ) uut (.*);

    // byte address of a register is num*32 + sel*4
    function automatic logic [9:0] byte_addr(input cp0_pkg::cp0_addr_t a);
        return 10'(a.num) * 10'd32 + 10'(a.sel) * 10'd4;
    endfunction

    function automatic logic [31:0] cause_value(input logic bd, input logic [4:0] code);
        return {bd, 24'h0, code, 2'b00};
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            mismatches++;
            $display("Mismatch at %0t ns: %s is %08h, expected %08h", $time, what, got, exp);
        end
    endtask

    // all bus tasks start and end just after a falling edge
    task automatic axil_write(input cp0_pkg::cp0_addr_t a, input logic [31:0] data,
                              input logic [3:0] strb);
        int waited;
        awaddr  = byte_addr(a);
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        waited  = 0;
        @(negedge clk);
        while (!(awready && wready) && waited < HS_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!(awready && wready)) begin
            failures++;
            $display("write to cp0 %0d.%0d was never accepted", a.num, a.sel);
            awvalid = 1'b0;
            wvalid  = 1'b0;
            return;
        end
        @(negedge clk); // the handshake edge is behind us
        awvalid = 1'b0;
        wvalid  = 1'b0;
        checks++;
        assert (bvalid && bresp == cp0_pkg::AXI_OKAY) else begin
            failures++;
            $display("no OKAY write response at %0t ns", $time);
        end
        @(negedge clk);
    endtask

    task automatic axil_read(input cp0_pkg::cp0_addr_t a, output logic [31:0] data,
                             input int stall);
        int waited;
        data    = '0;
        araddr  = byte_addr(a);
        arvalid = 1'b1;
        rready  = 1'b0;
        waited  = 0;
        @(negedge clk);
        while (!arready && waited < HS_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!arready) begin
            failures++;
            $display("read of cp0 %0d.%0d was never accepted", a.num, a.sel);
            arvalid = 1'b0;
            return;
        end
        @(negedge clk);
        arvalid = 1'b0;
        data    = rdata;
        checks++;
        assert (rvalid && rresp == cp0_pkg::AXI_OKAY) else begin
            failures++;
            $display("no OKAY read response at %0t ns", $time);
        end
        repeat (stall) begin
            @(negedge clk);
            checks++;
            assert (rvalid && rdata === data) else begin
                failures++;
                $display("read response changed while rready was low at %0t ns", $time);
            end
        end
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
        checks++;
        assert (!rvalid) else begin
            failures++;
            $display("rvalid stayed high after the read completed at %0t ns", $time);
        end
    endtask

    task automatic check_read(input string what, input cp0_pkg::cp0_addr_t a,
                              input logic [31:0] exp);
        logic [31:0] got;
        axil_read(a, got, 0);
        check_value(what, got, exp);
    endtask

    // writes random data and expects only the writable bits to change
    task automatic check_mask(input string what, input cp0_pkg::cp0_addr_t a,
                              input logic [31:0] mask, input logic [31:0] old);
        logic [31:0] data;
        data = $random(seed);
        axil_write(a, data, 4'hf);
        check_read(what, a, (old & ~mask) | (data & mask));
    endtask

    task automatic raise_exception(input cp0_pkg::exc_req_t req);
        exc_req       = req;
        exc_req.valid = 1'b1;
        @(negedge clk);
        exc_req = '0;
        @(negedge clk); // the encoder output lands one edge after its request
    endtask

    task automatic pulse_eret();
        eret = 1'b1;
        @(negedge clk);
        eret = 1'b0;
    endtask

    task automatic watchdog();
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("simulation still running after %0d cycles, stopped", WATCHDOG_CYCLES);
        $display("Errors found");
        $finish;
    endtask

    task automatic test_reset_values();
        cp0_pkg::cp0_addr_t unmapped;
        unmapped = '{num: 5'd1, sel: 3'd0};
        check_read("Status at reset", cp0_pkg::STATUS, cp0_pkg::STATUS_RESET);
        check_read("Config at reset", cp0_pkg::CONFIG, cp0_pkg::CONFIG_RESET);
        check_read("Config1 at reset", cp0_pkg::CONFIG1, cp0_pkg::CONFIG1_RESET);
        check_read("Cause at reset", cp0_pkg::CAUSE, 32'h0);
        check_read("unmapped register", unmapped, 32'h0);
        check_value("view.config_k0 at reset", {29'h0, view.config_k0},
                    {29'h0, cp0_pkg::CONFIG_RESET[2:0]});
    endtask

    task automatic test_write_masks();
        logic [31:0] data;
        logic [31:0] got;
        check_mask("Index", cp0_pkg::INDEX, 32'h0000_000f, 32'h0);
        check_mask("EntryLo0", cp0_pkg::ENTRYLO0, 32'h03ff_ffff, 32'h0);
        check_mask("EntryLo1", cp0_pkg::ENTRYLO1, 32'h03ff_ffff, 32'h0);
        check_mask("EntryHi", cp0_pkg::ENTRYHI, 32'hffff_e0ff, 32'h0);
        check_mask("Compare", cp0_pkg::COMPARE, 32'hffff_ffff, 32'h0);
        check_mask("Status", cp0_pkg::STATUS, 32'h0000_ff03, cp0_pkg::STATUS_RESET);
        check_mask("Cause", cp0_pkg::CAUSE, 32'h0000_0300, 32'h0);
        check_mask("EPC", cp0_pkg::EPC, 32'hffff_ffff, 32'h0);
        check_mask("Config", cp0_pkg::CONFIG, 32'h0000_0007, cp0_pkg::CONFIG_RESET);
        check_mask("Config1", cp0_pkg::CONFIG1, 32'h0, cp0_pkg::CONFIG1_RESET);
        data = $random(seed);
        axil_write(cp0_pkg::COUNT, data, 4'hf);
        axil_read(cp0_pkg::COUNT, got, 0);
        checks++;
        assert (got - data <= 32'd8) else begin
            mismatches++;
            $display("Mismatch at %0t ns: Count is %08h, expected %08h plus a few ticks",
                     $time, got, data);
        end
        axil_write(cp0_pkg::STATUS, 32'h0, 4'hf);
        axil_write(cp0_pkg::CAUSE, 32'h0, 4'hf);
        axil_write(cp0_pkg::COMPARE, 32'h0, 4'hf);
    endtask

    task automatic test_exceptions();
        cp0_pkg::exc_req_t req;
        req               = '0;
        req.pc            = 32'h8000_1004;
        req.in_delay_slot = 1'b1;
        req.syscall       = 1'b1;
        raise_exception(req);
        check_read("Cause after syscall", cp0_pkg::CAUSE, cause_value(1'b1, cp0_pkg::SYS));
        check_read("EPC after syscall", cp0_pkg::EPC, 32'h8000_1000);
        check_value("view.epc after syscall", view.epc, 32'h8000_1000);
        check_read("Status after syscall", cp0_pkg::STATUS, cp0_pkg::STATUS_RESET | 32'h2);

        // nested under exl, only the code and BadVAddr move
        req           = '0;
        req.pc        = 32'h8000_2000;
        req.data_ades = 1'b1;
        req.bad_addr  = 32'h1234_5677;
        raise_exception(req);
        check_read("Cause after nested AdES", cp0_pkg::CAUSE, cause_value(1'b1, cp0_pkg::ADES));
        check_read("EPC after nested AdES", cp0_pkg::EPC, 32'h8000_1000);
        check_read("BadVAddr after AdES", cp0_pkg::BADVADDR, 32'h1234_5677);
        axil_write(cp0_pkg::BADVADDR, 32'hedcb_a988, 4'hf); // BadVAddr is read only
        check_read("BadVAddr after write", cp0_pkg::BADVADDR, 32'h1234_5677);
        pulse_eret();
        check_read("Status after eret", cp0_pkg::STATUS, cp0_pkg::STATUS_RESET);

        req            = '0;
        req.pc         = 32'hbfc0_0203;
        req.fetch_adel = 1'b1;
        req.ov         = 1'b1;
        raise_exception(req);
        check_read("Cause after fetch AdEL", cp0_pkg::CAUSE, cause_value(1'b0, cp0_pkg::ADEL));
        check_read("EPC after fetch AdEL", cp0_pkg::EPC, 32'hbfc0_0203);
        check_read("BadVAddr after fetch AdEL", cp0_pkg::BADVADDR, 32'hbfc0_0203);
        pulse_eret();
    endtask

    task automatic test_timer();
        int cycles;
        axil_write(cp0_pkg::STATUS, 32'h0000_8001, 4'hf); // IM7 and IE
        axil_write(cp0_pkg::COMPARE, TIMER_COMPARE, 4'hf);
        axil_write(cp0_pkg::COUNT, 32'h0, 4'hf);
        cycles = 0;
        while (!int_pending && cycles < 2 * TIMER_COMPARE + 4) begin
            @(negedge clk);
            cycles++;
        end
        checks++;
        assert (int_pending) else begin
            failures++;
            $display("timer interrupt did not raise int_pending within %0d cycles", cycles);
        end
        check_read("Cause with timer pending", cp0_pkg::CAUSE,
                   cause_value(1'b0, cp0_pkg::ADEL) | 32'h4000_8000);
        axil_write(cp0_pkg::COMPARE, 32'h0, 4'hf);
        @(negedge clk);
        check_value("int_pending after Compare write", {31'h0, int_pending}, 32'h0);
        check_read("Cause after Compare write", cp0_pkg::CAUSE, cause_value(1'b0, cp0_pkg::ADEL));
        axil_write(cp0_pkg::STATUS, 32'h0, 4'hf);
    endtask

    task automatic test_ext_irq();
        int cycles;
        axil_write(cp0_pkg::STATUS, 32'h0000_1001, 4'hf); // IM4 and IE
        irq    = 6'b000100;
        cycles = 0;
        while (!int_pending && cycles < 4) begin
            @(negedge clk);
            cycles++;
        end
        check_value("int_pending with irq[2]", {31'h0, int_pending}, 32'h1);
        check_read("Cause with irq[2]", cp0_pkg::CAUSE,
                   cause_value(1'b0, cp0_pkg::ADEL) | 32'h0000_1000);
        axil_write(cp0_pkg::STATUS, 32'h0000_1000, 4'hf);
        check_value("int_pending with IE clear", {31'h0, int_pending}, 32'h0);
        axil_write(cp0_pkg::STATUS, 32'h0000_1003, 4'hf);
        check_value("int_pending under EXL", {31'h0, int_pending}, 32'h0);
        irq = 6'h0;
        axil_write(cp0_pkg::STATUS, 32'h0, 4'hf);
    endtask

    task automatic test_tlb_backpressure();
        cp0_pkg::tlb_result_t t;
        logic [31:0]          held;
        t.probe_valid = 1'b1;
        t.read_valid  = 1'b1;
        t.index       = $random(seed);
        t.entryhi     = $random(seed);
        t.entrylo0    = $random(seed);
        t.entrylo1    = $random(seed);
        tlb = t;
        @(negedge clk);
        tlb = '0;
        @(negedge clk);
        check_value("view.index", view.index, t.index);
        check_value("view.entryhi", view.entryhi, t.entryhi);
        check_value("view.entrylo0", view.entrylo0, t.entrylo0);
        check_value("view.entrylo1", view.entrylo1, t.entrylo1);
        check_read("EntryHi after tlbr", cp0_pkg::ENTRYHI, t.entryhi);
        check_read("EntryLo0 after tlbr", cp0_pkg::ENTRYLO0, t.entrylo0);
        check_read("EntryLo1 after tlbr", cp0_pkg::ENTRYLO1, t.entrylo1);
        check_read("Index after tlbp", cp0_pkg::INDEX, t.index);
        // the held response keeps the EntryHi value while rready is low
        axil_read(cp0_pkg::ENTRYHI, held, 6);
        check_value("EntryHi read under back-pressure", held, t.entryhi);
    endtask

    initial begin
        watchdog();
    end

    initial begin
        seed       = 32'h0efb_147a;
        checks     = 0;
        mismatches = 0;
        failures   = 0;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = 4'h0;
        wvalid     = 1'b0;
        bready     = 1'b1;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        irq        = 6'h0;
        exc_req    = '0;
        eret       = 1'b0;
        tlb        = '0;
        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end

        test_reset_values();
        test_write_masks();
        test_exceptions();
        test_timer();
        test_ext_irq();
        test_tlb_backpressure();

        $display("%0d checks, %0d mismatches, %0d other errors", checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
design/cp0_pkg.sv
design/cp0_axil_port.sv
design/exc_encoder.sv
design/cp0_regs.sv
design/cp0_top.sv
test/tb_clock.sv
test/cp0_tb.sv

// ==== run.sh ====
#!/bin/sh
# builds the cp0 testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module cp0_tb -Mdir obj_dir \
        > build.log 2>&1 \
    && ./obj_dir/Vcp0_tb > sim.log 2>&1 \
    && grep -qx "No errors" sim.log \
    && echo "PASS" \
    || { echo "FAIL (see build.log and sim.log)"; exit 1; }
